// File: mem_pkg.sv
`default_nettype none

package mem_pkg;

    // Core-side address and data widths
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;

    // Direct-mapped geometry, one word per line
    localparam int OFFSET_W = 2;
    localparam int INDEX_W  = 4;
    localparam int LINES    = 1 << INDEX_W;
    localparam int TAG_W    = ADDR_W - OFFSET_W - INDEX_W;

    // Load kinds as issued by the core
    typedef enum logic [2:0] {
        LOAD_NONE = 3'b000,
        LOAD_B_S  = 3'b010,
        LOAD_B_U  = 3'b011,
        LOAD_H_S  = 3'b100,
        LOAD_H_U  = 3'b101,
        LOAD_W    = 3'b110
    } load_op_e;

    // Store kinds
    typedef enum logic [1:0] {
        STORE_NONE = 2'b00,
        STORE_B    = 2'b01,
        STORE_H    = 2'b10,
        STORE_W    = 2'b11
    } store_op_e;

    // Data cache bus sequencer
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WRITE
    } cache_state_e;

endpackage

`default_nettype wire

// File: bus_pkg.sv
`default_nettype none

package bus_pkg;

    // Wishbone word bus
    localparam int WB_ADR_W   = 30;
    localparam int WB_DAT_W   = 32;
    localparam int WB_SEL_W   = WB_DAT_W / 8;

    // On-chip SRAM size in words
    localparam int SRAM_AW    = 8;
    localparam int SRAM_DEPTH = 1 << SRAM_AW;

    // Current bus owner
    typedef enum logic [1:0] {
        GNT_NONE  = 2'b00,
        GNT_DATA  = 2'b01,
        GNT_INSTR = 2'b10
    } grant_e;

endpackage

`default_nettype wire

// File: wb_if.sv
`default_nettype none

// Wishbone classic, single transfers only
interface wb_if;

    logic                          cyc;
    logic                          stb;
    logic                          we;
    logic [bus_pkg::WB_SEL_W-1:0]  sel;
    logic [bus_pkg::WB_ADR_W-1:0]  adr;
    logic [bus_pkg::WB_DAT_W-1:0]  dat_w;
    logic [bus_pkg::WB_DAT_W-1:0]  dat_r;
    logic                          ack;

    modport master (
        output cyc, stb, we, sel, adr, dat_w,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, sel, adr, dat_w,
        output dat_r, ack
    );

endinterface

`default_nettype wire

// File: data_cache.sv
`default_nettype none

module data_cache (
    input  wire logic                          CLK,
    input  wire logic                          rst_n,
    input  wire logic [mem_pkg::ADDR_W-1:0]    read_addr,
    input  wire mem_pkg::load_op_e             load_op,
    input  wire logic [mem_pkg::ADDR_W-1:0]    write_addr,
    input  wire logic [mem_pkg::DATA_W-1:0]    write_data,
    input  wire mem_pkg::store_op_e            store_op,
    output logic                               dc_ready,
    output logic                               load_valid,
    output logic [mem_pkg::DATA_W-1:0]         load_data,
    wb_if.master                               bus
);

    mem_pkg::cache_state_e               state;
    logic                                cyc_q;

    logic [mem_pkg::TAG_W-1:0]           tag_mem  [mem_pkg::LINES];
    logic [mem_pkg::DATA_W-1:0]          data_mem [mem_pkg::LINES];
    logic [mem_pkg::LINES-1:0]           valid;

    logic [mem_pkg::INDEX_W-1:0]         rd_index;
    logic [mem_pkg::TAG_W-1:0]           rd_tag;
    logic                                rd_hit;
    logic [mem_pkg::INDEX_W-1:0]         bus_index;
    logic [mem_pkg::TAG_W-1:0]           bus_tag;
    logic                                bus_hit;

    logic [bus_pkg::WB_SEL_W-1:0]        st_sel;
    logic [bus_pkg::WB_DAT_W-1:0]        st_data;
    mem_pkg::load_op_e                   req_load;
    logic [mem_pkg::OFFSET_W-1:0]        req_off;

    // Byte or half pick by offset, then extend
    function automatic logic [mem_pkg::DATA_W-1:0] extract_load(
        input mem_pkg::load_op_e               op,
        input logic [mem_pkg::OFFSET_W-1:0]    off,
        input logic [mem_pkg::DATA_W-1:0]      word
    );
        logic [7:0]                  byte_v;
        logic [15:0]                 half_v;
        logic [mem_pkg::DATA_W-1:0]  result;
        byte_v = word[{off, 3'b000} +: 8];
        half_v = word[{off[1], 4'b0000} +: 16];
        case (op)
            mem_pkg::LOAD_B_S: result = {{24{byte_v[7]}}, byte_v};
            mem_pkg::LOAD_B_U: result = {24'b0, byte_v};
            mem_pkg::LOAD_H_S: result = {{16{half_v[15]}}, half_v};
            mem_pkg::LOAD_H_U: result = {16'b0, half_v};
            default:           result = word;
        endcase
        return result;
    endfunction

    ////////////////////////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////////////////////////

    assign rd_index  = read_addr[mem_pkg::OFFSET_W +: mem_pkg::INDEX_W];
    assign rd_tag    = read_addr[mem_pkg::ADDR_W-1 -: mem_pkg::TAG_W];
    assign rd_hit    = valid[rd_index] && (tag_mem[rd_index] == rd_tag);

    // Line addressed by the cycle in flight
    assign bus_index = bus.adr[mem_pkg::INDEX_W-1:0];
    assign bus_tag   = bus.adr[bus_pkg::WB_ADR_W-1:mem_pkg::INDEX_W];
    assign bus_hit   = valid[bus_index] && (tag_mem[bus_index] == bus_tag);

    // Lane-replicated store data, selects pick the bytes
    always_comb
    begin
        st_sel  = '1;
        st_data = write_data;
        case (store_op)
            mem_pkg::STORE_B:
            begin
                st_sel  = 4'b0001 << write_addr[1:0];
                st_data = {4{write_data[7:0]}};
            end
            mem_pkg::STORE_H:
            begin
                st_sel  = write_addr[1] ? 4'b1100 : 4'b0011;
                st_data = {2{write_data[15:0]}};
            end
            default:
            begin
                st_sel  = '1;
                st_data = write_data;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= mem_pkg::ST_IDLE;
            cyc_q      <= 1'b0;
            load_valid <= 1'b0;
            valid      <= '0;
        end
        else
        begin
            load_valid <= 1'b0;
            case (state)
                mem_pkg::ST_IDLE:
                begin
                    if (store_op != mem_pkg::STORE_NONE)
                    begin
                        state <= mem_pkg::ST_WRITE;
                        cyc_q <= 1'b1;
                    end
                    else if (load_op != mem_pkg::LOAD_NONE)
                    begin
                        if (rd_hit)
                        begin
                            load_valid <= 1'b1;
                        end
                        else
                        begin
                            state <= mem_pkg::ST_READ;
                            cyc_q <= 1'b1;
                        end
                    end
                end
                mem_pkg::ST_READ:
                begin
                    if (bus.ack)
                    begin
                        state            <= mem_pkg::ST_IDLE;
                        cyc_q            <= 1'b0;
                        load_valid       <= 1'b1;
                        valid[bus_index] <= 1'b1;
                    end
                end
                default:
                begin
                    if (bus.ack)
                    begin
                        state <= mem_pkg::ST_IDLE;
                        cyc_q <= 1'b0;
                    end
                end
            endcase
        end
    end

    // Request capture, line arrays and returned data
    always_ff @(posedge CLK)
    begin
        if (state == mem_pkg::ST_IDLE)
        begin
            if (store_op != mem_pkg::STORE_NONE)
            begin
                bus.we    <= 1'b1;
                bus.adr   <= write_addr[mem_pkg::ADDR_W-1:mem_pkg::OFFSET_W];
                bus.sel   <= st_sel;
                bus.dat_w <= st_data;
            end
            else if (load_op != mem_pkg::LOAD_NONE)
            begin
                bus.we   <= 1'b0;
                bus.adr  <= read_addr[mem_pkg::ADDR_W-1:mem_pkg::OFFSET_W];
                bus.sel  <= '1;
                req_load <= load_op;
                req_off  <= read_addr[mem_pkg::OFFSET_W-1:0];
                if (rd_hit)
                begin
                    load_data <= extract_load(load_op, read_addr[1:0], data_mem[rd_index]);
                end
            end
        end
        else if (state == mem_pkg::ST_READ && bus.ack)
        begin
            load_data           <= extract_load(req_load, req_off, bus.dat_r);
            data_mem[bus_index] <= bus.dat_r;
            tag_mem[bus_index]  <= bus_tag;
        end
        else if (state == mem_pkg::ST_WRITE && bus.ack && bus_hit)
        begin
            // Write-through hit, merge the stored lanes
            for (int i = 0; i < bus_pkg::WB_SEL_W; i++)
            begin
                if (bus.sel[i])
                begin
                    data_mem[bus_index][8*i +: 8] <= bus.dat_w[8*i +: 8];
                end
            end
        end
    end

    assign bus.cyc  = cyc_q;
    assign bus.stb  = cyc_q;
    assign dc_ready = (state == mem_pkg::ST_IDLE);

endmodule

`default_nettype wire

// File: instr_cache.sv
`default_nettype none

module instr_cache (
    input  wire logic                          CLK,
    input  wire logic                          rst_n,
    input  wire logic                          fetch_req,
    input  wire logic [mem_pkg::ADDR_W-1:0]    fetch_addr,
    output logic                               fetch_ready,
    output logic                               fetch_valid,
    output logic [mem_pkg::DATA_W-1:0]         fetch_instr,
    wb_if.master                               bus
);

    logic                                cyc_q;
    logic [mem_pkg::TAG_W-1:0]           tag_mem  [mem_pkg::LINES];
    logic [mem_pkg::DATA_W-1:0]          data_mem [mem_pkg::LINES];
    logic [mem_pkg::LINES-1:0]           valid;

    logic                                accept;
    logic [mem_pkg::INDEX_W-1:0]         f_index;
    logic [mem_pkg::TAG_W-1:0]           f_tag;
    logic                                f_hit;
    logic [mem_pkg::INDEX_W-1:0]         fill_index;

    assign accept     = fetch_req && fetch_ready;
    assign f_index    = fetch_addr[mem_pkg::OFFSET_W +: mem_pkg::INDEX_W];
    assign f_tag      = fetch_addr[mem_pkg::ADDR_W-1 -: mem_pkg::TAG_W];
    assign f_hit      = valid[f_index] && (tag_mem[f_index] == f_tag);
    assign fill_index = bus.adr[mem_pkg::INDEX_W-1:0];

    // Busy for the whole miss
    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cyc_q       <= 1'b0;
            fetch_valid <= 1'b0;
            valid       <= '0;
        end
        else
        begin
            fetch_valid <= 1'b0;
            if (accept && f_hit)
            begin
                fetch_valid <= 1'b1;
            end
            else if (accept)
            begin
                cyc_q <= 1'b1;
            end
            else if (cyc_q && bus.ack)
            begin
                cyc_q             <= 1'b0;
                fetch_valid       <= 1'b1;
                valid[fill_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            bus.adr     <= fetch_addr[mem_pkg::ADDR_W-1:mem_pkg::OFFSET_W];
            fetch_instr <= data_mem[f_index];
        end
        else if (cyc_q && bus.ack)
        begin
            fetch_instr          <= bus.dat_r;
            data_mem[fill_index] <= bus.dat_r;
            tag_mem[fill_index]  <= bus.adr[bus_pkg::WB_ADR_W-1:mem_pkg::INDEX_W];
        end
    end

    // Read-only master
    assign bus.cyc     = cyc_q;
    assign bus.stb     = cyc_q;
    assign bus.we      = 1'b0;
    assign bus.sel     = '1;
    assign bus.dat_w   = '0;
    assign fetch_ready = !cyc_q;

endmodule

`default_nettype wire

// File: wb_arbiter.sv
`default_nettype none

module wb_arbiter (
    input  wire logic   CLK,
    input  wire logic   rst_n,
    wb_if.slave         dmst,
    wb_if.slave         imst,
    wb_if.master        slv
);

    bus_pkg::grant_e    owner_q;
    bus_pkg::grant_e    grant;

    // Keep the owner while its cyc is up, else data first
    always_comb
    begin
        if (owner_q == bus_pkg::GNT_DATA && dmst.cyc)
            grant = bus_pkg::GNT_DATA;
        else if (owner_q == bus_pkg::GNT_INSTR && imst.cyc)
            grant = bus_pkg::GNT_INSTR;
        else if (dmst.cyc)
            grant = bus_pkg::GNT_DATA;
        else if (imst.cyc)
            grant = bus_pkg::GNT_INSTR;
        else
            grant = bus_pkg::GNT_NONE;
    end

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
            owner_q <= bus_pkg::GNT_NONE;
        else
            owner_q <= grant;
    end

    ////////////////////////////////////////////////////////////
    // Request mux toward the SRAM
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        slv.cyc   = 1'b0;
        slv.stb   = 1'b0;
        slv.we    = 1'b0;
        slv.sel   = '0;
        slv.adr   = '0;
        slv.dat_w = '0;
        case (grant)
            bus_pkg::GNT_DATA:
            begin
                slv.cyc   = dmst.cyc;
                slv.stb   = dmst.stb;
                slv.we    = dmst.we;
                slv.sel   = dmst.sel;
                slv.adr   = dmst.adr;
                slv.dat_w = dmst.dat_w;
            end
            bus_pkg::GNT_INSTR:
            begin
                slv.cyc   = imst.cyc;
                slv.stb   = imst.stb;
                slv.we    = imst.we;
                slv.sel   = imst.sel;
                slv.adr   = imst.adr;
                slv.dat_w = imst.dat_w;
            end
            default:
            begin
                slv.cyc = 1'b0;
            end
        endcase
    end

    // Read data is shared, ack only to the owner
    assign dmst.dat_r = slv.dat_r;
    assign imst.dat_r = slv.dat_r;
    assign dmst.ack   = slv.ack && (grant == bus_pkg::GNT_DATA);
    assign imst.ack   = slv.ack && (grant == bus_pkg::GNT_INSTR);

endmodule

`default_nettype wire

// File: wb_sram.sv
`default_nettype none

module wb_sram (
    input  wire logic   CLK,
    input  wire logic   rst_n,
    wb_if.slave         bus
);

    logic [bus_pkg::WB_DAT_W-1:0]   mem [bus_pkg::SRAM_DEPTH];
    logic [bus_pkg::SRAM_AW-1:0]    word;
    logic                           ack_q;
    logic                           take;

    // Word address wraps to the array size
    assign word = bus.adr[bus_pkg::SRAM_AW-1:0];

    // One transfer per ack, idle cycle in between
    assign take = bus.cyc && bus.stb && !ack_q;

    initial
    begin
        for (int i = 0; i < bus_pkg::SRAM_DEPTH; i++)
        begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (take)
        begin
            if (bus.we)
            begin
                for (int i = 0; i < bus_pkg::WB_SEL_W; i++)
                begin
                    if (bus.sel[i])
                        mem[word][8*i +: 8] <= bus.dat_w[8*i +: 8];
                end
            end
            bus.dat_r <= mem[word];
        end
    end

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
            ack_q <= 1'b0;
        else
            ack_q <= take;
    end

    assign bus.ack = ack_q;

endmodule

`default_nettype wire

// File: mem_subsystem.sv
`default_nettype none

module mem_subsystem (
    input  wire logic                          CLK,
    input  wire logic                          rst_n,

    // Core data port
    input  wire logic [mem_pkg::ADDR_W-1:0]    read_addr,
    input  wire mem_pkg::load_op_e             load_op,
    input  wire logic [mem_pkg::ADDR_W-1:0]    write_addr,
    input  wire logic [mem_pkg::DATA_W-1:0]    write_data,
    input  wire mem_pkg::store_op_e            store_op,
    output logic                               dc_ready,
    output logic                               load_valid,
    output logic [mem_pkg::DATA_W-1:0]         load_data,

    // Core fetch port
    input  wire logic                          fetch_req,
    input  wire logic [mem_pkg::ADDR_W-1:0]    fetch_addr,
    output logic                               fetch_ready,
    output logic                               fetch_valid,
    output logic [mem_pkg::DATA_W-1:0]         fetch_instr
);

    wb_if dbus ();
    wb_if ibus ();
    wb_if sbus ();

    data_cache u_data_cache (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .read_addr  (read_addr),
        .load_op    (load_op),
        .write_addr (write_addr),
        .write_data (write_data),
        .store_op   (store_op),
        .dc_ready   (dc_ready),
        .load_valid (load_valid),
        .load_data  (load_data),
        .bus        (dbus.master)
    );

    instr_cache u_instr_cache (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_ready (fetch_ready),
        .fetch_valid (fetch_valid),
        .fetch_instr (fetch_instr),
        .bus         (ibus.master)
    );

    // Data side wins a same-cycle request
    wb_arbiter u_wb_arbiter (
        .CLK   (CLK),
        .rst_n (rst_n),
        .dmst  (dbus.slave),
        .imst  (ibus.slave),
        .slv   (sbus.master)
    );

    wb_sram u_wb_sram (
        .CLK   (CLK),
        .rst_n (rst_n),
        .bus   (sbus.slave)
    );

endmodule

`default_nettype wire

// File: mem_subsystem_sva.sv
`default_nettype none

module mem_subsystem_sva (
    input  wire logic                          CLK,
    input  wire logic                          rst_n,
    input  wire mem_pkg::load_op_e             load_op,
    input  wire mem_pkg::store_op_e            store_op,
    input  wire logic                          dc_ready,
    input  wire logic                          load_valid,
    input  wire logic                          cyc,
    input  wire logic [bus_pkg::WB_ADR_W-1:0]  adr,
    input  wire logic                          ack
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // One request kind per cycle on the core side
    one_request: assert property (@(posedge CLK) disable iff (!rst_n)
        !(load_op != mem_pkg::LOAD_NONE && store_op != mem_pkg::STORE_NONE))
        else
        begin
            $error("load and store requested in the same cycle");
            fail_count++;
        end

    valid_when_ready: assert property (@(posedge CLK) disable iff (!rst_n)
        load_valid |-> dc_ready)
        else
        begin
            $error("load_valid high while dc_ready is low");
            fail_count++;
        end

    // Wishbone request held until the slave answers
    hold_until_ack: assert property (@(posedge CLK) disable iff (!rst_n)
        cyc && !ack |=> cyc && $stable(adr))
        else
        begin
            $error("cyc dropped or adr changed before ack");
            fail_count++;
        end

endmodule

bind data_cache mem_subsystem_sva u_sva (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .load_op    (load_op),
    .store_op   (store_op),
    .dc_ready   (dc_ready),
    .load_valid (load_valid),
    .cyc        (bus.cyc),
    .adr        (bus.adr),
    .ack        (bus.ack)
);

`default_nettype wire

// File: mem_subsystem_tb.sv
`default_nettype none

module mem_subsystem_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int SEED     = 32'h4956_6cb6;
    localparam int TIMEOUT  = 50;
    localparam int N_WORDS  = 8;
    localparam int N_LANE   = 2;
    localparam int N_UPD    = 4;
    localparam int N_ALIAS  = 2;
    localparam int N_ROUNDS = 6;
    // Data and fetch operations over all tests
    localparam int NUM_OPS  = 3 * N_WORDS + 9 + 13 * N_LANE + 3 * N_UPD
                            + 6 * N_ALIAS + 4 * N_ROUNDS;

    logic                           CLK = 1'b0;
    logic                           rst_n;
    logic [mem_pkg::ADDR_W-1:0]     read_addr;
    mem_pkg::load_op_e              load_op;
    logic [mem_pkg::ADDR_W-1:0]     write_addr;
    logic [mem_pkg::DATA_W-1:0]     write_data;
    mem_pkg::store_op_e             store_op;
    logic                           dc_ready;
    logic                           load_valid;
    logic [mem_pkg::DATA_W-1:0]     load_data;
    logic                           fetch_req;
    logic [mem_pkg::ADDR_W-1:0]     fetch_addr;
    logic                           fetch_ready;
    logic                           fetch_valid;
    logic [mem_pkg::DATA_W-1:0]     fetch_instr;

    // Model of the SRAM contents
    logic [31:0]    model_mem [256];
    logic [31:0]    exp_load_q [$];
    string          name_load_q [$];
    logic [31:0]    exp_fetch_q [$];
    string          name_fetch_q [$];

    int             checks = 0;
    int             errors = 0;
    int             op_num;
    int             checks_before;
    int             errors_before;
    string          test_name;

    always #20 CLK = ~CLK;

    mem_subsystem UUT (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .read_addr   (read_addr),
        .load_op     (load_op),
        .write_addr  (write_addr),
        .write_data  (write_data),
        .store_op    (store_op),
        .dc_ready    (dc_ready),
        .load_valid  (load_valid),
        .load_data   (load_data),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_ready (fetch_ready),
        .fetch_valid (fetch_valid),
        .fetch_instr (fetch_instr)
    );

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // Word wraps to 256 entries and the lane comes from the low address bits
    function automatic logic [31:0] expected_result(
        input mem_pkg::load_op_e op,
        input logic [31:0]       addr
    );
        logic [31:0] word;
        logic [7:0]  b;
        logic [15:0] h;
        word = model_mem[addr[9:2]];
        b    = word[8 * addr[1:0] +: 8];
        h    = word[16 * addr[1] +: 16];
        case (op)
            mem_pkg::LOAD_B_S: return {{24{b[7]}}, b};
            mem_pkg::LOAD_B_U: return {24'h0, b};
            mem_pkg::LOAD_H_S: return {{16{h[15]}}, h};
            mem_pkg::LOAD_H_U: return {16'h0, h};
            default:           return word;
        endcase
    endfunction

    function automatic void apply_store(
        input mem_pkg::store_op_e op,
        input logic [31:0]        addr,
        input logic [31:0]        data
    );
        case (op)
            mem_pkg::STORE_B: model_mem[addr[9:2]][8 * addr[1:0] +: 8] = data[7:0];
            mem_pkg::STORE_H: model_mem[addr[9:2]][16 * addr[1] +: 16] = data[15:0];
            default:          model_mem[addr[9:2]] = data;
        endcase
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Mismatch %s: expected %h, actual %h", name, exp, act);
        errors++;
    endtask

    task automatic compare_result(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
        checks++;
        assert (act === exp) else report_mismatch(name, exp, act);
    endtask

    // Inputs change 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge CLK);
        #2;
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        op_num        = 0;
        checks_before = checks;
        errors_before = errors;
    endtask

    task automatic finish_test();
        next_cycle();
        $display("%-28s %0d checks, %0d errors", test_name,
                 checks - checks_before, errors - errors_before);
    endtask

    ////////////////////////////////////////////////////////////
    // Core-side requests
    ////////////////////////////////////////////////////////////

    task automatic do_store(input mem_pkg::store_op_e op, input logic [31:0] addr,
                            input logic [31:0] data);
        string name;
        int    waited;
        name = $sformatf("%s op %0d", test_name, op_num);
        op_num++;
        next_cycle();
        assert (dc_ready) else report_failure({name, ": data port busy before a store"});
        apply_store(op, addr, data);
        write_addr = addr;
        write_data = data;
        store_op   = op;
        next_cycle();
        store_op = mem_pkg::STORE_NONE;
        waited   = 1;
        @(negedge CLK);
        while (!dc_ready && waited < TIMEOUT)
        begin
            @(negedge CLK);
            waited++;
        end
        assert (dc_ready) else report_failure({name, ": store never completed"});
    endtask

    // Hit loads must answer one cycle after acceptance
    task automatic do_load(input mem_pkg::load_op_e op, input logic [31:0] addr,
                           input bit hit);
        string name;
        int    waited;
        name = $sformatf("%s op %0d", test_name, op_num);
        op_num++;
        next_cycle();
        assert (dc_ready) else report_failure({name, ": data port busy before a load"});
        exp_load_q.push_back(expected_result(op, addr));
        name_load_q.push_back(name);
        read_addr = addr;
        load_op   = op;
        next_cycle();
        load_op = mem_pkg::LOAD_NONE;
        waited  = 1;
        @(negedge CLK);
        while (!load_valid && waited < TIMEOUT)
        begin
            @(negedge CLK);
            waited++;
        end
        assert (load_valid) else report_failure({name, ": load got no response in time"});
        if (hit && load_valid)
            assert (waited == 1) else report_mismatch({name, " hit latency"}, 1, waited);
    endtask

    task automatic do_fetch(input logic [31:0] addr);
        string name;
        int    waited;
        name = $sformatf("%s fetch %0d", test_name, op_num);
        op_num++;
        next_cycle();
        assert (fetch_ready) else report_failure({name, ": fetch port busy"});
        exp_fetch_q.push_back(expected_result(mem_pkg::LOAD_W, addr));
        name_fetch_q.push_back(name);
        fetch_addr = addr;
        fetch_req  = 1'b1;
        next_cycle();
        fetch_req = 1'b0;
        waited    = 1;
        @(negedge CLK);
        while (!fetch_valid && waited < TIMEOUT)
        begin
            @(negedge CLK);
            waited++;
        end
        assert (fetch_valid) else report_failure({name, ": fetch got no response in time"});
    endtask

    // Results are sampled mid-cycle
    initial
    begin
        forever
        begin
            @(negedge CLK);
            if (load_valid)
            begin
                if (exp_load_q.size() == 0)
                    report_failure("load_valid seen with no load outstanding");
                else
                    compare_result(name_load_q.pop_front(), exp_load_q.pop_front(), load_data);
            end
            if (fetch_valid)
            begin
                if (exp_fetch_q.size() == 0)
                    report_failure("fetch_valid seen with no fetch outstanding");
                else
                    compare_result(name_fetch_q.pop_front(), exp_fetch_q.pop_front(),
                                   fetch_instr);
            end
        end
    end

    initial
    begin
        repeat (NUM_OPS * TIMEOUT + 200) @(posedge CLK);
        $display("Watchdog expired, the run did not complete in %0d cycles",
                 NUM_OPS * TIMEOUT + 200);
        $display("Simulation finished: FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        logic [31:0] d;
        logic [31:0] a;
        logic [31:0] b;
        void'($urandom(SEED));
        rst_n      = 1'b0;
        read_addr  = '0;
        load_op    = mem_pkg::LOAD_NONE;
        write_addr = '0;
        write_data = '0;
        store_op   = mem_pkg::STORE_NONE;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        for (int i = 0; i < 256; i++)
            model_mem[i] = '0;
        repeat (4) @(posedge CLK);
        #2;
        rst_n = 1'b1;
        assert (dc_ready && fetch_ready && !load_valid && !fetch_valid)
            else report_failure("core-side outputs not idle after reset");

        start_test("word store and load");
        for (int i = 0; i < N_WORDS; i++)
            do_store(mem_pkg::STORE_W, 32'h100 + 4 * i, $urandom());
        for (int i = 0; i < N_WORDS; i++)
        begin
            do_load(mem_pkg::LOAD_W, 32'h100 + 4 * i, 1'b0);
            do_load(mem_pkg::LOAD_W, 32'h100 + 4 * i, 1'b1);
        end
        finish_test();

        // First word is cached before the lane stores and the second is not
        start_test("byte and half merge");
        do_store(mem_pkg::STORE_W, 32'h200, $urandom());
        do_load(mem_pkg::LOAD_W, 32'h200, 1'b0);
        do_store(mem_pkg::STORE_B, 32'h201, $urandom());
        do_store(mem_pkg::STORE_H, 32'h202, $urandom());
        do_load(mem_pkg::LOAD_W, 32'h200, 1'b1);
        do_store(mem_pkg::STORE_W, 32'h204, $urandom());
        do_store(mem_pkg::STORE_B, 32'h207, $urandom());
        do_store(mem_pkg::STORE_H, 32'h204, $urandom());
        do_load(mem_pkg::LOAD_W, 32'h204, 1'b0);
        finish_test();

        start_test("signed and unsigned loads");
        for (int w = 0; w < N_LANE; w++)
        begin
            // All bytes positive in the first word and negative in the second
            d = (w == 0) ? ($urandom() & 32'h7f7f_7f7f) : ($urandom() | 32'h8080_8080);
            do_store(mem_pkg::STORE_W, 32'h300 + 4 * w, d);
            for (int off = 0; off < 4; off++)
            begin
                do_load(mem_pkg::LOAD_B_S, 32'h300 + 4 * w + off, 1'b0);
                do_load(mem_pkg::LOAD_B_U, 32'h300 + 4 * w + off, 1'b0);
            end
            for (int off = 0; off < 4; off += 2)
            begin
                do_load(mem_pkg::LOAD_H_S, 32'h300 + 4 * w + off, 1'b0);
                do_load(mem_pkg::LOAD_H_U, 32'h300 + 4 * w + off, 1'b0);
            end
        end
        finish_test();

        start_test("store hit update");
        for (int i = 0; i < N_UPD; i++)
        begin
            do_load(mem_pkg::LOAD_W, 32'h140 + 4 * i, 1'b0);
            do_store(mem_pkg::STORE_W, 32'h140 + 4 * i, $urandom());
            do_load(mem_pkg::LOAD_W, 32'h140 + 4 * i, 1'b1);
        end
        finish_test();

        // Same SRAM word and cache index but a different tag
        start_test("1 KiB alias");
        for (int i = 0; i < N_ALIAS; i++)
        begin
            a = 32'h80 + 4 * i;
            b = a + ((i == 0) ? 32'h400 : 32'h0010_0000);
            do_store(mem_pkg::STORE_W, a, $urandom());
            do_load(mem_pkg::LOAD_W, a, 1'b0);
            do_load(mem_pkg::LOAD_W, b, 1'b0);
            do_store(mem_pkg::STORE_W, b, $urandom());
            do_load(mem_pkg::LOAD_W, b, 1'b1);
            do_load(mem_pkg::LOAD_W, a, 1'b0);
        end
        finish_test();

        start_test("fetch with data traffic");
        for (int i = 0; i < N_ROUNDS; i++)
        begin
            fork
                do_store(mem_pkg::STORE_W, 32'h180 + 4 * i, $urandom());
                do_fetch(32'h100 + 4 * i);
            join
            fork
                do_load(mem_pkg::LOAD_W, 32'h180 + 4 * i, 1'b0);
                do_fetch(32'h100 + 4 * i);
            join
        end
        finish_test();

        next_cycle();
        assert (exp_load_q.size() == 0 && exp_fetch_q.size() == 0)
            else report_failure("responses still outstanding at the end of the run");
        assert (UUT.u_data_cache.u_sva.fail_count == 0)
            else report_failure("protocol assertions on the data cache failed");
        $display("Totals: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: mem_subsystem.f
mem_pkg.sv
bus_pkg.sv
wb_if.sv
data_cache.sv
instr_cache.sv
wb_arbiter.sv
wb_sram.sv
mem_subsystem.sv
mem_subsystem_sva.sv
mem_subsystem_tb.sv
